// File: design/cfg_params.svh
`ifndef CFG_PARAMS_SVH
`define CFG_PARAMS_SVH

// ========================================
// identity of this function
// ========================================
`define CFG_VENDOR_ID         16'h1d6c
`define CFG_DEVICE_ID         16'h0a41
`define CFG_SUBSYS_VENDOR_ID  16'h1d6c
`define CFG_SUBSYS_ID         16'h0001
`define CFG_CLASS             8'h03      // display controller
`define CFG_SUBCLASS          8'h80      // other
`define CFG_PROGIF            8'h01
`define CFG_REVISION_ID       8'h02
`define CFG_CACHE_LINE_SIZE   8'h08      // in 32-bit units
`define CFG_HEADER_TYPE       8'h00      // general device

// config address of this function inside padr[27:12]
`define CFG_BUS               8'd0
`define CFG_DEVICE            5'd3
`define CFG_FUNC              3'd0

// ========================================
// BARs, rom word and command reset
// ========================================
`define CFG_BAR0_RESET        32'hD000_0000
`define CFG_BAR1_RESET        32'hD010_0000
`define CFG_BAR2_RESET        32'hD020_0000
`define CFG_BAR0_MASK         32'hFFF0_0000  // 1 MB window
`define CFG_BAR1_MASK         32'hFFFF_0000  // 64 kB window
`define CFG_BAR2_MASK         32'hFFFF_F000  // 4 kB window
`define CFG_ROM_ADDR          32'hFFFF_FFF0
`define CFG_CMD_RESET         16'h4003

// interrupts and queueing
`define CFG_NIRQ              2
`define CFG_HOLDOFF_W         6          // 64 cycle holdoff per line
`define CFG_RDQ_DEPTH         4
`define CFG_IRQQ_DEPTH        8
`define CFG_RSP_CREDITS       4

`endif

// File: design/cfg_pkg.sv
package cfg_pkg;

  // ========================================
  // bus field widths
  // ========================================
  typedef logic [31:0] addr_t;     // physical bus address
  typedef logic [63:0] data_t;     // two-word data lane
  typedef logic [7:0]  sel_t;      // one enable per byte lane
  typedef logic [11:0] tid_t;      // transaction id, routes the response
  typedef logic [2:0]  pri_t;      // response priority
  typedef logic [8:0]  reg_off_t;  // doubleword index, padr[11:3]

  // request as seen on the bus, valid for one cycle while cyc is high
  typedef struct packed {
    logic  cyc;
    logic  we;
    sel_t  sel;
    addr_t padr;
    data_t dat;
    tid_t  tid;
  } cfg_req_t;

  typedef struct packed {
    logic  ack;   // one cycle per response
    tid_t  tid;
    addr_t adr;   // all ones on interrupt messages
    data_t dat;
    pri_t  pri;
  } cfg_rsp_t;

  // per-line interrupt descriptor, written as two words
  // low word is the message payload
  typedef struct packed {
    logic [12:0] resv;
    pri_t        pri;      // priority of the message
    logic [3:0]  resvt;
    tid_t        tid;      // target of the message
    logic [7:0]  resvs;
    logic [7:0]  cause;
    logic [7:0]  bus;      // source identity
    logic [4:0]  device;
    logic [2:0]  func;
  } irq_info_t;

  typedef struct packed {
    tid_t        tid;
    pri_t        pri;
    logic [31:0] payload;
  } irq_msg_t;

  // which queue feeds the response register this cycle
  typedef enum logic [1:0] {
    idle,
    send_reply,
    send_irq
  } merge_sel_e;

endpackage

// File: design/cfg_regfile.sv
`timescale 1ns/1ps
`include "cfg_params.svh"

module cfg_regfile import cfg_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                cs_i,
  input  cfg_req_t                            req_i,
  output logic                                reply_valid_o,
  output cfg_rsp_t                            reply_o,
  output irq_info_t [`CFG_NIRQ-1:0]           irq_info_o,
  output logic                                int_disable_o,
  input  logic [`CFG_NIRQ-1:0]                irq_pend_i,
  output logic                                cs_bar0_o,
  output logic                                cs_bar1_o,
  output logic                                cs_bar2_o
);

  localparam reg_off_t DESC_OFF = 9'd8;  // first descriptor slot
  localparam pri_t     REPLY_PRI = 3'd7;

  logic       cfg_sel;                   // access aimed at this function
  logic       cfg_wr;
  logic       cfg_rd;
  reg_off_t   offset;
  logic [15:0] cmd_q;
  logic [15:0] cmd_rd;                   // command with forced bits
  logic [15:0] stat_rd;
  addr_t      bar0_q;
  addr_t      bar1_q;
  addr_t      bar2_q;
  irq_info_t [`CFG_NIRQ-1:0] irq_info_q;
  data_t      rd_dat;

  // byte-lane merge for one BAR half, all ones is a sizing probe
  function automatic addr_t bar_wr(addr_t cur, addr_t mask, logic [3:0] be, logic [31:0] d);
    addr_t nxt;
    nxt = cur;
    if (&be && d == 32'hFFFF_FFFF) begin
      nxt = mask;                        // software reads back the size
    end else begin
      for (int b = 0; b < 4; b++)
        if (be[b]) nxt[b*8 +: 8] = d[b*8 +: 8];
    end
    return nxt;
  endfunction

  // ========================================
  // access decode
  // ========================================
  assign cfg_sel = cs_i && req_i.cyc &&
                   req_i.padr[27:20] == `CFG_BUS &&
                   req_i.padr[19:15] == `CFG_DEVICE &&
                   req_i.padr[14:12] == `CFG_FUNC;
  assign cfg_wr = cfg_sel && req_i.we;
  assign cfg_rd = cfg_sel && !req_i.we;
  assign offset = req_i.padr[11:3];

  always_comb begin
    cmd_rd = cmd_q;
    cmd_rd[5:3] = 3'b000;                // no special cycles, mwi, palette snoop
    cmd_rd[7] = 1'b0;
    cmd_rd[9] = 1'b1;                    // fast back-to-back always on
    cmd_rd[15:11] = 5'd0;
  end
  assign int_disable_o = cmd_rd[10];

  always_comb begin
    stat_rd = 16'h0000;
    stat_rd[3] = |irq_pend_i;            // live interrupt status
    stat_rd[5] = 1'b1;                   // 66 MHz capable
    stat_rd[7] = 1'b1;                   // fast back-to-back capable
    stat_rd[10:9] = 2'b01;               // medium devsel
  end

  // ========================================
  // writable registers
  // ========================================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cmd_q <= `CFG_CMD_RESET;
      bar0_q <= `CFG_BAR0_RESET;
      bar1_q <= `CFG_BAR1_RESET;
      bar2_q <= `CFG_BAR2_RESET;
      irq_info_q <= '0;
    end else if (cfg_wr) begin
      case (offset)
        9'd0: begin                      // command sits in the upper word
          if (req_i.sel[4]) cmd_q[7:0] <= req_i.dat[39:32];
          if (req_i.sel[5]) cmd_q[15:8] <= req_i.dat[47:40];
        end
        9'd2: begin
          bar0_q <= bar_wr(bar0_q, `CFG_BAR0_MASK, req_i.sel[3:0], req_i.dat[31:0]);
          bar1_q <= bar_wr(bar1_q, `CFG_BAR1_MASK, req_i.sel[7:4], req_i.dat[63:32]);
        end
        9'd3: bar2_q <= bar_wr(bar2_q, `CFG_BAR2_MASK, req_i.sel[3:0], req_i.dat[31:0]);
        default: begin
          // descriptors only take whole words
          for (int i = 0; i < `CFG_NIRQ; i++) begin
            if (offset == DESC_OFF + reg_off_t'(i)) begin
              if (&req_i.sel[3:0]) irq_info_q[i][31:0] <= req_i.dat[31:0];
              if (&req_i.sel[7:4]) irq_info_q[i][63:32] <= req_i.dat[63:32];
            end
          end
        end
      endcase
    end
  end
  assign irq_info_o = irq_info_q;

  // ========================================
  // read mux and reply register
  // ========================================
  always_comb begin
    rd_dat = '0;                         // unmapped offsets read zero
    case (offset)
      9'd0: rd_dat = {stat_rd, cmd_rd, `CFG_DEVICE_ID, `CFG_VENDOR_ID};
      9'd1: rd_dat = {8'h00, `CFG_HEADER_TYPE, 8'h00, `CFG_CACHE_LINE_SIZE,
                      `CFG_CLASS, `CFG_SUBCLASS, `CFG_PROGIF, `CFG_REVISION_ID};
      9'd2: rd_dat = {bar1_q, bar0_q};
      9'd3: rd_dat = {32'hFFFF_FFFF, bar2_q};
      9'd4: rd_dat = '1;                 // unimplemented BARs
      9'd5: rd_dat = {`CFG_SUBSYS_ID, `CFG_SUBSYS_VENDOR_ID, 32'h0};
      9'd6: rd_dat = {32'h0, `CFG_ROM_ADDR};
      default: begin
        for (int i = 0; i < `CFG_NIRQ; i++)
          if (offset == DESC_OFF + reg_off_t'(i)) rd_dat = irq_info_q[i];
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reply_valid_o <= 1'b0;
    end else begin
      reply_valid_o <= cfg_rd;
      if (cfg_rd) begin
        reply_o <= '{ack: 1'b1, tid: req_i.tid, adr: req_i.padr, dat: rd_dat, pri: REPLY_PRI};
      end
    end
  end

  // BAR windows, compared against the live BAR under its size mask
  assign cs_bar0_o = req_i.cyc && ((req_i.padr ^ bar0_q) & `CFG_BAR0_MASK) == '0;
  assign cs_bar1_o = req_i.cyc && ((req_i.padr ^ bar1_q) & `CFG_BAR1_MASK) == '0;
  assign cs_bar2_o = req_i.cyc && ((req_i.padr ^ bar2_q) & `CFG_BAR2_MASK) == '0;

endmodule

// File: design/irq_msg_gen.sv
`timescale 1ns/1ps
`include "cfg_params.svh"

module irq_msg_gen import cfg_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [`CFG_NIRQ-1:0]      irq_i,
  input  irq_info_t [`CFG_NIRQ-1:0] irq_info_i,
  input  logic                      int_disable_i,
  input  logic                      msg_ready_i,
  output logic                      msg_valid_o,
  output irq_msg_t                  msg_o
);

  localparam int GW = (`CFG_NIRQ > 1) ? $clog2(`CFG_NIRQ) : 1;

  logic [`CFG_HOLDOFF_W-1:0] timer_q [`CFG_NIRQ];
  logic [`CFG_NIRQ-1:0]      pend_q;
  logic [GW-1:0]             pick;       // lowest pending line
  logic [GW-1:0]             grant;
  logic [GW-1:0]             grant_q;
  logic                      lock_q;     // offered message not yet taken
  logic                      take;

  // ========================================
  // line select
  // ========================================
  always_comb begin
    pick = '0;
    for (int i = `CFG_NIRQ - 1; i >= 0; i--)
      if (pend_q[i]) pick = GW'(i);      // last hit is the lowest index
  end

  // once offered, the winner is frozen so the message cannot change
  assign grant = lock_q ? grant_q : pick;
  assign msg_valid_o = |pend_q;
  assign take = msg_valid_o && msg_ready_i;

  always_comb begin
    msg_o.tid = irq_info_i[grant].tid;
    msg_o.pri = irq_info_i[grant].pri;
    msg_o.payload = irq_info_i[grant][31:0];
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q <= 1'b0;
    end else if (take) begin
      lock_q <= 1'b0;
    end else if (msg_valid_o) begin
      lock_q <= 1'b1;
      grant_q <= grant;
    end
  end

  // ========================================
  // holdoff timers and pending flags
  // ========================================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= '0;
      for (int i = 0; i < `CFG_NIRQ; i++)
        timer_q[i] <= '1;                // lines are ready straight out of reset
    end else begin
      for (int i = 0; i < `CFG_NIRQ; i++) begin
        if (take && grant == GW'(i)) begin
          pend_q[i] <= 1'b0;
          timer_q[i] <= '0;              // restart holdoff
        end else begin
          if (irq_i[i] && &timer_q[i] && !int_disable_i)
            pend_q[i] <= 1'b1;
          if (!(&timer_q[i]))
            timer_q[i] <= timer_q[i] + 1'b1; // saturates at all ones
        end
      end
    end
  end

  // an offered message stays put until the merger takes it
  a_msg_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    msg_valid_o && !msg_ready_i |=> msg_valid_o && $stable(msg_o));

endmodule

// File: design/rsp_merge.sv
`timescale 1ns/1ps
`include "cfg_params.svh"

module rsp_merge import cfg_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     reply_valid_i,
  input  cfg_rsp_t reply_i,
  input  logic     msg_valid_i,
  input  irq_msg_t msg_i,
  input  logic     rsp_credit_i,
  output logic     msg_ready_o,
  output cfg_rsp_t rsp_o
);

  localparam int RDQ_AW = $clog2(`CFG_RDQ_DEPTH);
  localparam int IRQQ_AW = $clog2(`CFG_IRQQ_DEPTH);
  localparam int CRED_W = $clog2(`CFG_RSP_CREDITS + 1);

  // ========================================
  // reply queue, falls through when empty
  // ========================================
  cfg_rsp_t          rdq_mem [`CFG_RDQ_DEPTH];
  logic [RDQ_AW-1:0] rdq_wr_q, rdq_rd_q; // depth is a power of two, pointers wrap
  logic [RDQ_AW:0]   rdq_cnt_q;
  logic              rdq_empty, rdq_avail, rdq_pop, rdq_store, rdq_drop;
  cfg_rsp_t          rdq_head;

  // interrupt queue
  irq_msg_t           irqq_mem [`CFG_IRQQ_DEPTH];
  logic [IRQQ_AW-1:0] irqq_wr_q, irqq_rd_q;
  logic [IRQQ_AW:0]   irqq_cnt_q;
  logic               irqq_push, irqq_pop;

  logic [CRED_W-1:0] credit_q;
  merge_sel_e        sel;
  logic              send;

  assign rdq_empty = rdq_cnt_q == '0;
  assign rdq_avail = !rdq_empty || reply_valid_i;
  assign rdq_head = rdq_empty ? reply_i : rdq_mem[rdq_rd_q];
  assign rdq_pop = sel == send_reply;
  assign rdq_store = reply_valid_i && !(rdq_empty && rdq_pop); // bypassed reply never lands
  assign rdq_drop = rdq_pop && !rdq_empty;

  always_ff @(posedge clk_i) begin
    if (rdq_store) rdq_mem[rdq_wr_q] <= reply_i;
    if (irqq_push) irqq_mem[irqq_wr_q] <= msg_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdq_wr_q <= '0;
      rdq_rd_q <= '0;
      rdq_cnt_q <= '0;
    end else begin
      if (rdq_store) rdq_wr_q <= rdq_wr_q + 1'b1;
      if (rdq_drop) rdq_rd_q <= rdq_rd_q + 1'b1;
      rdq_cnt_q <= rdq_cnt_q + (RDQ_AW+1)'(rdq_store) - (RDQ_AW+1)'(rdq_drop);
    end
  end

  // ========================================
  // interrupt queue, backpressures the generator
  // ========================================
  assign msg_ready_o = irqq_cnt_q != (IRQQ_AW+1)'(`CFG_IRQQ_DEPTH);
  assign irqq_push = msg_valid_i && msg_ready_o;
  assign irqq_pop = sel == send_irq;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      irqq_wr_q <= '0;
      irqq_rd_q <= '0;
      irqq_cnt_q <= '0;
    end else begin
      if (irqq_push) irqq_wr_q <= irqq_wr_q + 1'b1;
      if (irqq_pop) irqq_rd_q <= irqq_rd_q + 1'b1;
      irqq_cnt_q <= irqq_cnt_q + (IRQQ_AW+1)'(irqq_push) - (IRQQ_AW+1)'(irqq_pop);
    end
  end

  // replies first, and nothing goes out without a credit
  always_comb begin
    sel = idle;
    if (credit_q != '0) begin
      if (rdq_avail) sel = send_reply;
      else if (irqq_cnt_q != '0) sel = send_irq;
    end
  end
  assign send = sel != idle;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_q <= CRED_W'(`CFG_RSP_CREDITS);
    end else begin
      case ({send, rsp_credit_i})
        2'b10: credit_q <= credit_q - 1'b1;
        2'b01: credit_q <= credit_q + 1'b1;
        default: ;                       // spend and return cancel
      endcase
    end
  end

  // ========================================
  // response register
  // ========================================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_o.ack <= 1'b0;
    end else begin
      rsp_o.ack <= send;
      case (sel)
        send_reply: begin
          rsp_o.tid <= rdq_head.tid;
          rsp_o.adr <= rdq_head.adr;
          rsp_o.dat <= rdq_head.dat;
          rsp_o.pri <= rdq_head.pri;
        end
        send_irq: begin
          rsp_o.tid <= irqq_mem[irqq_rd_q].tid;
          rsp_o.adr <= 32'hFFFF_FFFF;    // marks an interrupt message
          rsp_o.dat <= {32'h0, irqq_mem[irqq_rd_q].payload};
          rsp_o.pri <= irqq_mem[irqq_rd_q].pri;
        end
        default: ;
      endcase
    end
  end

  // requester must not have more reads outstanding than the queue holds
  a_rdq_overflow : assert property (@(posedge clk_i) disable iff (rst_i)
    !(rdq_store && rdq_cnt_q == (RDQ_AW+1)'(`CFG_RDQ_DEPTH) && !rdq_drop));

  // more credits returned than were ever spent
  a_credit_max : assert property (@(posedge clk_i) disable iff (rst_i)
    credit_q <= CRED_W'(`CFG_RSP_CREDITS));

endmodule

// File: design/cfg_space_top.sv
`timescale 1ns/1ps
`include "cfg_params.svh"

module cfg_space_top import cfg_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 cs_i,
  input  cfg_req_t             req_i,
  input  logic [`CFG_NIRQ-1:0] irq_i,
  input  logic                 rsp_credit_i,
  output cfg_rsp_t             rsp_o,
  output logic                 cs_bar0_o,
  output logic                 cs_bar1_o,
  output logic                 cs_bar2_o
);

  logic                      reply_valid;
  cfg_rsp_t                  reply;
  irq_info_t [`CFG_NIRQ-1:0] irq_info;
  logic                      int_disable;
  logic [`CFG_NIRQ-1:0]      irq_pend;   // raw lines for the status word
  logic                      msg_valid;
  logic                      msg_ready;
  irq_msg_t                  irq_msg;

  assign irq_pend = irq_i;

  cfg_regfile i_regfile (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cs_i          (cs_i),
    .req_i         (req_i),
    .reply_valid_o (reply_valid),
    .reply_o       (reply),
    .irq_info_o    (irq_info),
    .int_disable_o (int_disable),
    .irq_pend_i    (irq_pend),
    .cs_bar0_o     (cs_bar0_o),
    .cs_bar1_o     (cs_bar1_o),
    .cs_bar2_o     (cs_bar2_o)
  );

  irq_msg_gen i_irq_gen (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .irq_i         (irq_i),
    .irq_info_i    (irq_info),
    .int_disable_i (int_disable),
    .msg_ready_i   (msg_ready),
    .msg_valid_o   (msg_valid),
    .msg_o         (irq_msg)
  );

  rsp_merge i_merge (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .reply_valid_i (reply_valid),
    .reply_i       (reply),
    .msg_valid_i   (msg_valid),
    .msg_i         (irq_msg),
    .rsp_credit_i  (rsp_credit_i),
    .msg_ready_o   (msg_ready),
    .rsp_o         (rsp_o)
  );

endmodule

// File: sim/tb_cfg_space.sv
`timescale 1ns/1ps
`include "cfg_params.svh"

module tb_cfg_space import cfg_pkg::*; ();

  localparam int TIMEOUT = 400;          // cycles per reply wait
  localparam int IRQ_TIMEOUT = 600;      // cycles per interrupt wait

  logic                 clk_i;
  logic                 rst_i;
  logic                 cs;
  cfg_req_t             req;
  logic [`CFG_NIRQ-1:0] irq;
  logic                 rsp_credit;
  cfg_rsp_t             rsp;
  logic                 cs_bar0;
  logic                 cs_bar1;
  logic                 cs_bar2;

  int          err_value;
  int          err_other;
  int          cyc_cnt = 0;
  int          issue_cyc;
  int          last_reply_cyc;
  int          ack_cnt;
  int          owed;                     // credits not yet handed back
  logic        hold_credits;
  logic [31:0] lfsr;
  tid_t        next_tid;

  // shadow of the writable registers
  logic [15:0] sh_cmd;
  addr_t       sh_bar0;
  addr_t       sh_bar1;
  addr_t       sh_bar2;
  data_t       sh_desc [`CFG_NIRQ];

  tid_t     exp_tid_q [$];
  addr_t    exp_adr_q [$];
  data_t    exp_dat_q [$];
  string    exp_name_q [$];
  cfg_rsp_t irq_log [$];                 // interrupt responses as they arrive
  int       irq_cyc_q [$];

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;
  always @(posedge clk_i) cyc_cnt <= cyc_cnt + 1;

  cfg_space_top i_dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cs_i         (cs),
    .req_i        (req),
    .irq_i        (irq),
    .rsp_credit_i (rsp_credit),
    .rsp_o        (rsp),
    .cs_bar0_o    (cs_bar0),
    .cs_bar1_o    (cs_bar1),
    .cs_bar2_o    (cs_bar2)
  );

  // ========================================
  // helpers
  // ========================================
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  task automatic take_bits(input int n, output logic [63:0] r);
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[62:0], lfsr[0]};            // one step per bit
    end
  endtask

  // expected read word from the header layout and the shadow
  function automatic data_t ref_read(reg_off_t off, logic [`CFG_NIRQ-1:0] lines);
    logic [15:0] cmd;
    logic [15:0] stat;
    cmd = (sh_cmd & 16'h0747) | 16'h0200;       // 3,4,5,7,15:11 low, 9 high
    stat = 16'h02A0 | ((|lines) ? 16'h0008 : 16'h0000);
    case (off)
      9'd0: return {stat, cmd, `CFG_DEVICE_ID, `CFG_VENDOR_ID};
      9'd1: return {8'h00, `CFG_HEADER_TYPE, 8'h00, `CFG_CACHE_LINE_SIZE,
                    `CFG_CLASS, `CFG_SUBCLASS, `CFG_PROGIF, `CFG_REVISION_ID};
      9'd2: return {sh_bar1, sh_bar0};
      9'd3: return {32'hFFFF_FFFF, sh_bar2};
      9'd4: return '1;
      9'd5: return {`CFG_SUBSYS_ID, `CFG_SUBSYS_VENDOR_ID, 32'h0};
      9'd6: return {32'h0, `CFG_ROM_ADDR};
      9'd8: return sh_desc[0];
      9'd9: return sh_desc[1];
      default: return '0;
    endcase
  endfunction

  function automatic addr_t bar_next(addr_t cur, addr_t mask, logic [3:0] be, logic [31:0] d);
    logic [31:0] keep;
    if (be == 4'hF && d == 32'hFFFF_FFFF) return mask;  // sizing probe
    keep = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (cur & ~keep) | (d & keep);
  endfunction

  function automatic logic bar_hit(addr_t a, addr_t bar, addr_t mask);
    return (a & mask) == (bar & mask);
  endfunction

  // bus address of one doubleword in this function's config space
  function automatic addr_t cfg_addr(reg_off_t off);
    return {4'h0, `CFG_BUS, `CFG_DEVICE, `CFG_FUNC, off, 3'b000};
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      err_value++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_irq(input string name, input data_t desc, input int k);
    irq_info_t di;
    di = irq_info_t'(desc);
    check({name, " tid"}, 64'(di.tid), 64'(irq_log[k].tid));
    check({name, " pri"}, 64'(di.pri), 64'(irq_log[k].pri));
    check({name, " payload"}, {32'h0, desc[31:0]}, irq_log[k].dat);
  endtask

  // one bus cycle to this function's config space
  task automatic drive_req(input logic we, input reg_off_t off, input sel_t sel, input data_t dat);
    @(posedge clk_i);
    #1;
    cs = 1'b1;
    req.cyc = 1'b1;
    req.we = we;
    req.sel = sel;
    req.padr = cfg_addr(off);
    req.dat = dat;
    req.tid = next_tid;
    issue_cyc = cyc_cnt;
    @(posedge clk_i);
    #1;
    cs = 1'b0;
    req.cyc = 1'b0;
    next_tid++;
  endtask

  task automatic cfg_write(input reg_off_t off, input sel_t sel, input data_t dat);
    drive_req(1'b1, off, sel, dat);
    case (off)
      9'd0: begin                        // command in the upper word
        if (sel[4]) sh_cmd[7:0] = dat[39:32];
        if (sel[5]) sh_cmd[15:8] = dat[47:40];
      end
      9'd2: begin
        sh_bar0 = bar_next(sh_bar0, `CFG_BAR0_MASK, sel[3:0], dat[31:0]);
        sh_bar1 = bar_next(sh_bar1, `CFG_BAR1_MASK, sel[7:4], dat[63:32]);
      end
      9'd3: sh_bar2 = bar_next(sh_bar2, `CFG_BAR2_MASK, sel[3:0], dat[31:0]);
      9'd8, 9'd9: begin                  // whole words only
        if (&sel[3:0]) sh_desc[off[0]][31:0] = dat[31:0];
        if (&sel[7:4]) sh_desc[off[0]][63:32] = dat[63:32];
      end
      default: ;
    endcase
  endtask

  task automatic cfg_read(input reg_off_t off, input string name);
    exp_tid_q.push_back(next_tid);
    exp_adr_q.push_back(cfg_addr(off));
    exp_dat_q.push_back(ref_read(off, irq));
    exp_name_q.push_back(name);
    drive_req(1'b0, off, 8'hFF, '0);
  endtask

  // plain bus cycle with cs low that only the BAR decode sees
  task automatic probe_bars(input addr_t a);
    @(posedge clk_i);
    #1;
    req.cyc = 1'b1;
    req.we = 1'b0;
    req.padr = a;
    @(negedge clk_i);
    check("cs_bar0", 64'(bar_hit(a, sh_bar0, `CFG_BAR0_MASK)), 64'(cs_bar0));
    check("cs_bar1", 64'(bar_hit(a, sh_bar1, `CFG_BAR1_MASK)), 64'(cs_bar1));
    check("cs_bar2", 64'(bar_hit(a, sh_bar2, `CFG_BAR2_MASK)), 64'(cs_bar2));
    @(posedge clk_i);
    #1;
    req.cyc = 1'b0;
  endtask

  task automatic wait_replies(input string what);
    int n;
    n = 0;
    while (exp_tid_q.size() != 0 && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_tid_q.size() != 0) begin
      $display("timeout: %0d %s replies missing", exp_tid_q.size(), what);
      err_other++;
    end
  endtask

  task automatic wait_irqs(input int cnt, input string what);
    int n;
    n = 0;
    while (irq_log.size() < cnt && n < IRQ_TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    if (irq_log.size() < cnt) begin
      $display("timeout: only %0d of %0d interrupt messages for %s", irq_log.size(), cnt, what);
      err_other++;
    end
  endtask

  // ========================================
  // response compare and credit return
  // ========================================
  always @(negedge clk_i) begin : compare_rsp
    string nm;
    if (!rst_i && rsp.ack) begin
      ack_cnt++;
      if (rsp.adr == 32'hFFFF_FFFF) begin   // interrupt message
        irq_log.push_back(rsp);
        irq_cyc_q.push_back(cyc_cnt);
      end else if (exp_tid_q.size() == 0) begin
        $display("reply with tid %h arrived but none was expected", rsp.tid);
        err_other++;
      end else begin
        nm = exp_name_q.pop_front();
        check({nm, " tid"}, 64'(exp_tid_q.pop_front()), 64'(rsp.tid));
        check({nm, " adr"}, 64'(exp_adr_q.pop_front()), 64'(rsp.adr));
        check(nm, exp_dat_q.pop_front(), rsp.dat);
        last_reply_cyc = cyc_cnt;
      end
    end
  end

  always @(negedge clk_i) begin
    if (!rst_i && rsp.ack) owed++;
  end

  always @(posedge clk_i) begin
    #1;
    if (!rst_i && !hold_credits && owed > 0) begin
      rsp_credit = 1'b1;                 // one credit per cycle
      owed--;
    end else begin
      rsp_credit = 1'b0;
    end
  end

  initial begin
    #100_000;
    $display("watchdog expired before the tests finished");
    $display(">>> FAIL");
    $finish;
  end

  // ========================================
  // test sequence
  // ========================================
  initial begin : main
    logic [63:0] r;
    addr_t       a;
    data_t       d0;
    data_t       d1;
    int          base;
    int          irq_before;
    rst_i = 1'b1;
    cs = 1'b0;
    req = '0;
    irq = '0;
    rsp_credit = 1'b0;
    hold_credits = 1'b0;
    owed = 0;
    ack_cnt = 0;
    err_value = 0;
    err_other = 0;
    lfsr = 32'h182f;
    next_tid = 12'h100;
    sh_cmd = `CFG_CMD_RESET;
    sh_bar0 = `CFG_BAR0_RESET;
    sh_bar1 = `CFG_BAR1_RESET;
    sh_bar2 = `CFG_BAR2_RESET;
    sh_desc[0] = '0;
    sh_desc[1] = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // header reads where the first one also checks the idle latency
    cfg_read(9'd0, "hdr0");
    wait_replies("hdr0");
    check("hdr0 latency", 64'(2), 64'(last_reply_cyc - issue_cyc));
    for (int o = 1; o <= 6; o++) cfg_read(reg_off_t'(o), $sformatf("hdr%0d", o));
    cfg_read(9'd7, "unmapped7");
    cfg_read(9'd300, "unmapped300");
    wait_replies("header");

    // random command values
    for (int i = 0; i < 8; i++) begin
      take_bits(16, r);
      cfg_write(9'd0, 8'h30, {16'h0, r[15:0], 32'h0});
      cfg_read(9'd0, "cmd_rand");
    end
    cfg_write(9'd0, 8'h30, {16'h0, 16'h0007, 32'h0});  // interrupts enabled again
    wait_replies("command");

    // BAR byte lanes, sizing, then decode
    for (int i = 0; i < 4; i++) begin
      take_bits(8, r);
      a = r[31:0];
      take_bits(64, r);
      cfg_write(9'd2, a[7:0], r);
      take_bits(64, r);
      cfg_write(9'd3, {4'h0, a[3:0]}, r);
      cfg_read(9'd2, "bar_lanes01");
      cfg_read(9'd3, "bar_lanes2");
    end
    cfg_write(9'd2, 8'hFF, '1);
    cfg_write(9'd3, 8'h0F, '1);
    cfg_read(9'd2, "bar_size01");
    cfg_read(9'd3, "bar_size2");
    cfg_write(9'd2, 8'hFF, {32'h5001_0000, 32'h4000_0000});
    cfg_write(9'd3, 8'h0F, {32'h0, 32'h6000_2000});
    cfg_read(9'd2, "bar_prog01");
    cfg_read(9'd3, "bar_prog2");
    wait_replies("bar");
    for (int i = 0; i < 24; i++) begin
      take_bits(32, r);
      case (i % 4)
        0: a = (sh_bar0 & `CFG_BAR0_MASK) | (r[31:0] & ~`CFG_BAR0_MASK);
        1: a = (sh_bar1 & `CFG_BAR1_MASK) | (r[31:0] & ~`CFG_BAR1_MASK);
        2: a = (sh_bar2 & `CFG_BAR2_MASK) | (r[31:0] & ~`CFG_BAR2_MASK);
        default: a = r[31:0];            // mostly misses
      endcase
      probe_bars(a);
    end

    // descriptors with distinct targets
    take_bits(64, r);
    d0 = r;
    d0[43:32] = 12'hA01;
    take_bits(64, r);
    d1 = r;
    d1[43:32] = 12'hA02;
    cfg_write(9'd8, 8'hFF, d0);
    cfg_write(9'd9, 8'hFF, d1);
    cfg_write(9'd9, 8'h7E, '1);          // partial lanes are ignored
    cfg_read(9'd8, "desc0");
    cfg_read(9'd9, "desc1");
    wait_replies("descriptor");

    // line 0 held so its repeats are rate limited
    irq_log.delete();
    irq_cyc_q.delete();
    @(posedge clk_i);
    #1;
    irq = 2'b01;
    wait_irqs(3, "line 0 held");
    @(posedge clk_i);
    #1;
    irq = '0;
    for (int k = 0; k < irq_log.size(); k++) check_irq("irq_line0", d0, k);
    for (int k = 1; k < irq_cyc_q.size(); k++) begin
      if (irq_cyc_q[k] - irq_cyc_q[k-1] < 64) begin
        $display("line 0 fired again after only %0d cycles", irq_cyc_q[k] - irq_cyc_q[k-1]);
        err_other++;
      end
    end

    // both lines at once with line 0 served first
    repeat (80) @(posedge clk_i);
    irq_log.delete();
    irq_cyc_q.delete();
    @(posedge clk_i);
    #1;
    irq = 2'b11;
    wait_irqs(2, "both lines");
    @(posedge clk_i);
    #1;
    irq = '0;
    if (irq_log.size() >= 2) begin
      check_irq("irq_first", d0, 0);
      check_irq("irq_second", d1, 1);
    end

    // command bit 10 blocks new messages
    repeat (80) @(posedge clk_i);
    cfg_write(9'd0, 8'h30, {16'h0, 16'h0407, 32'h0});
    cfg_read(9'd0, "cmd_intdis");
    wait_replies("int disable");
    irq_log.delete();
    irq_cyc_q.delete();
    @(posedge clk_i);
    #1;
    irq = 2'b11;
    cfg_read(9'd0, "status_irq");        // status bit 3 follows the lines
    repeat (150) @(posedge clk_i);
    check("irq_disabled count", 64'(0), 64'(irq_log.size()));
    @(posedge clk_i);
    #1;
    irq = '0;
    cfg_write(9'd0, 8'h30, {16'h0, 16'h0007, 32'h0});
    wait_replies("status");

    // under credit starvation the replies keep order and beat the waiting message
    repeat (80) @(posedge clk_i);
    base = ack_cnt;
    @(negedge clk_i);
    hold_credits = 1'b1;
    for (int i = 0; i < 8; i++) cfg_read(reg_off_t'(i % 4), $sformatf("credit_rd%0d", i));
    @(posedge clk_i);
    #1;
    irq = 2'b01;
    repeat (20) @(posedge clk_i);
    #1;
    irq = '0;
    check("acks while starved", 64'(`CFG_RSP_CREDITS), 64'(ack_cnt - base));
    irq_before = irq_log.size();
    @(negedge clk_i);
    hold_credits = 1'b0;
    wait_replies("credit");
    check("irq count at last reply", 64'(irq_before), 64'(irq_log.size()));
    wait_irqs(irq_before + 1, "queued message");
    if (irq_log.size() > irq_before) check_irq("irq_after_credit", d0, irq_before);

    repeat (20) @(posedge clk_i);
    if (exp_tid_q.size() != 0 || owed != 0) begin
      $display("responses or credits still outstanding at the end");
      err_other++;
    end
    $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+design
design/cfg_pkg.sv
design/cfg_regfile.sv
design/irq_msg_gen.sv
design/rsp_merge.sv
design/cfg_space_top.sv
sim/tb_cfg_space.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := tb_cfg_space
FILELIST  := compile.f
BUILD     := obj_dir
LOG       := run.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
